//--- source/mpmc_pkg.sv
package mpmc_pkg;

	localparam int DATA_W = 64;
	localparam int SEL_W = DATA_W / 8; // one select bit per byte
	localparam int ADR_W = 28;
	localparam int CMD_W = 3;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [ADR_W-1:0] adr_t; // word address, also used as app_addr
	typedef logic [CMD_W-1:0] app_cmd_t;

	// command codes of the DDR controller app port
	localparam app_cmd_t APP_CMD_WRITE = app_cmd_t'(0);
	localparam app_cmd_t APP_CMD_READ = app_cmd_t'(1);

	// channel request, held stable by the client while cyc is high
	typedef struct packed {
		logic cyc;
		logic we; // store if high
		adr_t adr;
		sel_t sel;
		data_t data;
	} ch_req_t;

	typedef struct packed {
		logic ack;
		data_t data; // read data, valid with ack
	} ch_resp_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_CMD,
		SEQ_RD_WAIT,
		SEQ_DONE
	} seq_state_t;

endpackage : mpmc_pkg

//--- source/mpmc_ch_port.sv
`timescale 1ns/1ps

module mpmc_ch_port (
	input logic clk,
	input logic rst,
	input mpmc_pkg::ch_req_t ch_req,
	output mpmc_pkg::ch_resp_t ch_resp,
	output logic pending,
	output mpmc_pkg::ch_req_t req,
	input logic done,
	input mpmc_pkg::data_t rd_data
);

	import mpmc_pkg::*;

	logic ack;
	logic capture;
	data_t resp_data;

	// take a new request only once the previous handshake has closed
	assign capture = ch_req.cyc && !pending && !ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (capture) begin
			pending <= 1'b1;
		end else if (done) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			req <= ch_req; // held for the arbiter and sequencer
		end
	end

	// ack rises after done and falls once the client has dropped cyc
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else if (done) begin
			ack <= 1'b1;
		end else if (ack && !ch_req.cyc) begin
			ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			resp_data <= rd_data;
		end
	end

	always_comb begin
		ch_resp.ack = ack;
		ch_resp.data = resp_data;
	end

	// the sequencer only completes requests that this port has handed over
	done_while_pending: assert property (
		@(posedge clk) disable iff (rst)
		done |-> pending
	) else $error("done strobe on a port with no pending request");

endmodule : mpmc_ch_port

//--- source/mpmc_arbiter.sv
`timescale 1ns/1ps

module mpmc_arbiter #(
	parameter int NUM_CH = 4
) (
	input logic clk,
	input logic rst,
	input logic [NUM_CH-1:0] pending,
	input logic idle,
	output logic [NUM_CH-1:0] grant,
	output logic start
);

	localparam int IDX_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	logic [IDX_W-1:0] last; // last channel served
	logic [IDX_W-1:0] pick_idx;
	logic [NUM_CH-1:0] pick;
	logic launched; // sequencer has taken the current grant
	logic fire;

	// search starts one past the last channel served
	always_comb begin
		int idx;
		pick = '0;
		pick_idx = last;
		for (int i = 1; i <= NUM_CH; i++) begin
			idx = (int'(last) + i) % NUM_CH;
			if (pending[idx] && pick == '0) begin
				pick[idx] = 1'b1;
				pick_idx = IDX_W'(idx);
			end
		end
	end

	assign fire = idle && !start && (grant == '0 || launched) && (pending != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			start <= 1'b0;
			launched <= 1'b0;
			last <= IDX_W'(NUM_CH - 1); // first search begins at channel 0
		end else begin
			start <= (grant != '0) && !launched && !start; // one cycle after grant
			if (start) begin
				launched <= 1'b1;
			end
			if (fire) begin
				grant <= pick;
				last <= pick_idx;
				launched <= 1'b0;
			end else if (launched && idle) begin
				grant <= '0; // sequencer back in idle, nothing else waiting
				launched <= 1'b0;
			end
		end
	end

	grant_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(grant)
	) else $error("grant is not one-hot");

endmodule : mpmc_arbiter

//--- source/mpmc_app_seq.sv
`timescale 1ns/1ps

module mpmc_app_seq (
	input logic clk,
	input logic rst,
	input logic start,
	input mpmc_pkg::ch_req_t req,
	output logic idle,
	output logic done,
	output mpmc_pkg::data_t rd_data,
	output logic app_en,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::adr_t app_addr,
	input logic app_rdy,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output mpmc_pkg::data_t app_wdf_data,
	output mpmc_pkg::sel_t app_wdf_mask,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	input mpmc_pkg::data_t app_rd_data
);

	import mpmc_pkg::*;

	seq_state_t state;
	logic we;
	logic cmd_ok; // command already accepted
	logic wdf_ok; // write data already accepted, or none needed
	logic cmd_acc;
	logic wdf_acc;
	logic cmd_done;
	logic wdf_done;

	assign cmd_acc = app_en && app_rdy;
	assign wdf_acc = app_wdf_wren && app_wdf_rdy;
	assign cmd_done = cmd_ok || cmd_acc;
	assign wdf_done = wdf_ok || wdf_acc;

	assign idle = (state == SEQ_IDLE);
	assign done = (state == SEQ_DONE);
	assign app_wdf_end = app_wdf_wren; // every burst is a single word

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEQ_IDLE;
			app_en <= 1'b0;
			app_wdf_wren <= 1'b0;
			cmd_ok <= 1'b0;
			wdf_ok <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						app_en <= 1'b1;
						app_wdf_wren <= req.we;
						cmd_ok <= 1'b0;
						wdf_ok <= !req.we;
						state <= SEQ_CMD;
					end
				end
				SEQ_CMD: begin
					// command and write data may be taken in either order
					if (cmd_acc) begin
						app_en <= 1'b0;
						cmd_ok <= 1'b1;
					end
					if (wdf_acc) begin
						app_wdf_wren <= 1'b0;
						wdf_ok <= 1'b1;
					end
					if (cmd_done && wdf_done) begin
						state <= we ? SEQ_DONE : SEQ_RD_WAIT;
					end
				end
				SEQ_RD_WAIT: begin
					if (app_rd_data_valid) begin
						state <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// command fields are frozen at start so they stay put under back-pressure
	always_ff @(posedge clk) begin
		if (idle && start) begin
			we <= req.we;
			app_cmd <= req.we ? APP_CMD_WRITE : APP_CMD_READ;
			app_addr <= req.adr;
			app_wdf_data <= req.data;
			app_wdf_mask <= ~req.sel; // mask bit set means byte untouched
		end
	end

	always_ff @(posedge clk) begin
		if (state == SEQ_RD_WAIT && app_rd_data_valid) begin
			rd_data <= app_rd_data;
		end
	end

	cmd_hold: assert property (
		@(posedge clk) disable iff (rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr)
	) else $error("app command changed before it was accepted");

	// read data from the controller only ever answers the outstanding load
	rd_expected: assert property (
		@(posedge clk) disable iff (rst)
		app_rd_data_valid |-> state == SEQ_RD_WAIT
	) else $error("read data returned with no load outstanding");

endmodule : mpmc_app_seq

//--- source/mpmc.sv
`timescale 1ns/1ps

module mpmc #(
	parameter int NUM_CH = 4
) (
	input logic clk,
	input logic rst,
	input mpmc_pkg::ch_req_t ch_req [NUM_CH],
	output mpmc_pkg::ch_resp_t ch_resp [NUM_CH],
	output logic app_en,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::adr_t app_addr,
	input logic app_rdy,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output mpmc_pkg::data_t app_wdf_data,
	output mpmc_pkg::sel_t app_wdf_mask,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	input mpmc_pkg::data_t app_rd_data
);

	import mpmc_pkg::*;

	logic [NUM_CH-1:0] pending;
	logic [NUM_CH-1:0] grant;
	logic [NUM_CH-1:0] port_done;
	ch_req_t port_req [NUM_CH];
	ch_req_t seq_req;
	logic start;
	logic idle;
	logic seq_done;
	data_t rd_data;

	for (genvar i = 0; i < NUM_CH; i++) begin : g_port
		assign port_done[i] = seq_done && grant[i]; // done goes to the granted port only

		mpmc_ch_port port_i (
			.clk(clk),
			.rst(rst),
			.ch_req(ch_req[i]),
			.ch_resp(ch_resp[i]),
			.pending(pending[i]),
			.req(port_req[i]),
			.done(port_done[i]),
			.rd_data(rd_data)
		);
	end

	// grant is one-hot, so the last match is the only match
	always_comb begin
		seq_req = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			if (grant[i]) begin
				seq_req = port_req[i];
			end
		end
	end

	mpmc_arbiter #(
		.NUM_CH(NUM_CH)
	) arbiter_i (
		.clk(clk),
		.rst(rst),
		.pending(pending),
		.idle(idle),
		.grant(grant),
		.start(start)
	);

	mpmc_app_seq seq_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.req(seq_req),
		.idle(idle),
		.done(seq_done),
		.rd_data(rd_data),
		.app_en(app_en),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

endmodule : mpmc

//--- tb/mig_app_model.sv
`timescale 1ns/1ps

module mig_app_model (
	input logic clk,
	input logic rst,
	input logic app_en,
	input mpmc_pkg::app_cmd_t app_cmd,
	input mpmc_pkg::adr_t app_addr,
	output logic app_rdy,
	input logic app_wdf_wren,
	input logic app_wdf_end,
	input mpmc_pkg::data_t app_wdf_data,
	input mpmc_pkg::sel_t app_wdf_mask,
	output logic app_wdf_rdy,
	output logic app_rd_data_valid,
	output mpmc_pkg::data_t app_rd_data,
	output logic proto_err
);

	import mpmc_pkg::*;

	data_t mem [adr_t];
	adr_t wr_adr [$]; // write commands and write data may arrive in either order
	data_t wr_data [$];
	sel_t wr_mask [$];
	adr_t wadr;
	adr_t rd_adr;
	logic rd_busy;
	int unsigned rd_wait;
	logic err_flag = 1'b0;

	assign proto_err = err_flag;

	function automatic data_t fill_word(input adr_t a);
		return {a, 8'h5a, ~a}; // unwritten words carry their whole address
	endfunction

	function automatic data_t apply_mask(input data_t old_word, input data_t new_word,
			input sel_t mask);
		data_t word;
		word = old_word;
		for (int b = 0; b < SEL_W; b++) begin
			if (!mask[b]) begin
				word[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return word;
	endfunction

	initial begin
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		rd_busy = 1'b0;
		rd_adr = '0;
		rd_wait = 0;
		forever begin
			@(posedge clk);
			if (!rst) begin
				if (app_en && app_rdy) begin
					if (app_cmd == APP_CMD_WRITE) begin
						wr_adr.push_back(app_addr);
					end else begin
						rd_busy = 1'b1;
						rd_adr = app_addr;
						rd_wait = 3 + $urandom % 18; // 3 to 20 cycles
					end
				end
				if (app_wdf_wren && app_wdf_rdy && app_wdf_end) begin
					wr_data.push_back(app_wdf_data);
					wr_mask.push_back(app_wdf_mask);
				end
				if (wr_adr.size() != 0 && wr_data.size() != 0) begin
					wadr = wr_adr.pop_front();
					mem[wadr] = apply_mask(mem.exists(wadr) ? mem[wadr] : fill_word(wadr),
						wr_data.pop_front(), wr_mask.pop_front());
				end
			end
			#1;
			app_rdy = !rst && ($urandom % 4 != 0); // stall about one cycle in four
			app_wdf_rdy = !rst && ($urandom % 4 != 0);
			app_rd_data_valid = 1'b0;
			if (rd_busy) begin
				rd_wait = rd_wait - 1;
				if (rd_wait == 0) begin
					app_rd_data_valid = 1'b1;
					app_rd_data = mem.exists(rd_adr) ? mem[rd_adr] : fill_word(rd_adr);
					rd_busy = 1'b0;
				end
			end
		end
	end

	cmd_held: assert property (
		@(posedge clk) disable iff (rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr)
	) else err_flag = 1'b1;

	wdf_held: assert property (
		@(posedge clk) disable iff (rst)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data)
			&& $stable(app_wdf_mask)
	) else err_flag = 1'b1;

endmodule : mig_app_model

//--- tb/mpmc_tb.sv
`timescale 1ns/1ps

module mpmc_tb;

	import mpmc_pkg::*;

	localparam int NUM_CH = 4;
	localparam int REGION = 8; // words per channel in the random phase
	localparam int OPS = 80;
	localparam int unsigned MAX_CYCLES = 400 * 60;
	localparam logic [31:0] SEED = 32'h8df9_78f2;

	logic clk = 1'b0;
	logic rst;
	ch_req_t ch_req [NUM_CH];
	ch_resp_t ch_resp [NUM_CH];
	logic app_en;
	app_cmd_t app_cmd;
	adr_t app_addr;
	logic app_rdy;
	logic app_wdf_wren;
	logic app_wdf_end;
	data_t app_wdf_data;
	sel_t app_wdf_mask;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	data_t app_rd_data;
	logic app_err;

	data_t shadow [adr_t];
	logic started = 1'b0; // first cyc has been driven
	int unsigned cycles = 0;
	logic [NUM_CH-1:0] ack_vec;
	logic [NUM_CH-1:0] cyc_vec;
	logic [NUM_CH-1:0] ack_q;
	logic [NUM_CH-1:0] cyc_q;
	int unsigned wait_since [NUM_CH];
	int unsigned last_ack [NUM_CH];
	int unsigned acks [NUM_CH];

	always #5 clk = ~clk;

	mpmc #(
		.NUM_CH(NUM_CH)
	) mpmc_i (
		.clk(clk),
		.rst(rst),
		.ch_req(ch_req),
		.ch_resp(ch_resp),
		.app_en(app_en),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

	mig_app_model app_i (
		.clk(clk),
		.rst(rst),
		.app_en(app_en),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data),
		.proto_err(app_err)
	);

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic fail_value(input string msg);
		$display("Fail %0t: %s", $time, msg);
		stop_run();
	endtask

	function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
			input sel_t sel);
		data_t word;
		word = old_word;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				word[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return word;
	endfunction

	function automatic data_t random_word();
		return {$urandom, $urandom};
	endfunction

	// one four-phase transfer on channel c
	task automatic access(input int c, input logic we, input adr_t adr, input sel_t sel,
			input data_t wdata, output data_t rdata);
		@(posedge clk);
		#1;
		started = 1'b1;
		ch_req[c] = '{cyc: 1'b1, we: we, adr: adr, sel: sel, data: wdata};
		do begin
			@(posedge clk);
			#1;
		end while (!ch_resp[c].ack);
		rdata = ch_resp[c].data;
		ch_req[c].cyc = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (ch_resp[c].ack);
	endtask

	task automatic store(input int c, input adr_t adr, input sel_t sel, input data_t wdata);
		data_t rdata;
		access(c, 1'b1, adr, sel, wdata, rdata);
		shadow[adr] = merge_bytes(shadow.exists(adr) ? shadow[adr] : '0, wdata, sel);
	endtask

	task automatic load_check(input int c, input adr_t adr);
		data_t rdata;
		access(c, 1'b0, adr, '1, '0, rdata);
		load_data: assert (rdata == shadow[adr])
		else fail_value($sformatf("ch %0d load at %h returned %h, expected %h",
			c, adr, rdata, shadow[adr]));
	endtask

	task automatic directed_checks(input int c);
		adr_t adr;
		adr = adr_t'(28'h0ab_0000 + c);
		store(c, adr, '1, random_word());
		load_check(c, adr);
		store(c, adr, sel_t'(16'h3c3c >> c), random_word()); // partial select
		load_check(c, adr);
	endtask

	task automatic run_channel(input int c);
		adr_t base;
		adr_t adr;
		base = adr_t'((c + 1) << 8); // channels never share a word
		for (int i = 0; i < REGION; i++) begin
			store(c, base + adr_t'(i), '1, random_word());
		end
		for (int n = 0; n < OPS; n++) begin
			adr = base + adr_t'($urandom % REGION);
			if ($urandom % 2 == 1) begin
				store(c, adr, sel_t'($urandom), random_word());
			end else begin
				load_check(c, adr);
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		for (int c = 0; c < NUM_CH; c++) begin
			ch_req[c] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (5) @(posedge clk); // quiet window after reset
		for (int c = 0; c < NUM_CH; c++) begin
			directed_checks(c);
		end
		for (int c = 0; c < NUM_CH; c++) begin
			automatic int ch = c;
			fork
				run_channel(ch);
			join_none
		end
		wait fork;
		repeat (5) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// handshake bookkeeping and the round-robin order check
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run was still busy after %0d cycles", MAX_CYCLES);
			stop_run();
		end
		if (rst) begin
			ack_q <= '0;
			cyc_q <= '0;
			for (int c = 0; c < NUM_CH; c++) begin
				wait_since[c] <= 0;
				last_ack[c] <= 0;
				acks[c] <= 0;
			end
		end else begin
			ack_q <= ack_vec;
			cyc_q <= cyc_vec;
			for (int c = 0; c < NUM_CH; c++) begin
				if (cyc_vec[c] && !cyc_q[c]) begin
					wait_since[c] <= cycles;
					acks[c] <= 0;
				end
				if (ack_vec[c] && !ack_q[c]) begin
					acks[c] <= acks[c] + 1;
					last_ack[c] <= cycles;
					for (int j = 0; j < NUM_CH; j++) begin
						fair_order: assert (j == c || !cyc_q[j] || !cyc_vec[j] || ack_vec[j]
							|| wait_since[j] >= last_ack[c])
						else fail_value($sformatf("ch %0d served again while ch %0d waited",
							c, j));
					end
				end
			end
		end
	end

	for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
		assign ack_vec[c] = ch_resp[c].ack;
		assign cyc_vec[c] = ch_req[c].cyc;

		ack_needs_cyc: assert property (
			@(posedge clk) disable iff (rst)
			$rose(ack_vec[c]) |-> $past(cyc_vec[c])
		) else fail_value($sformatf("ack rose on ch %0d without cyc", c));

		ack_until_drop: assert property (
			@(posedge clk) disable iff (rst)
			$fell(ack_vec[c]) |-> !$past(cyc_vec[c])
		) else fail_value($sformatf("ack fell on ch %0d while cyc was high", c));

		// a second ack before the next cyc counts against the same request
		one_ack: assert property (
			@(posedge clk) disable iff (rst)
			$rose(ack_vec[c]) |-> acks[c] == 0
		) else fail_value($sformatf("ch %0d saw a second ack for one cyc", c));
	end

	quiet_after_reset: assert property (
		@(posedge clk) disable iff (rst)
		!started |-> ack_vec == '0 && !app_en && !app_wdf_wren
	) else fail_value("ack or app activity before any request");

	app_rules: assert property (
		@(posedge clk)
		!app_err
	) else fail_value("app command or write data changed before it was accepted");

endmodule : mpmc_tb

//--- mpmc.f
source/mpmc_pkg.sv
source/mpmc_ch_port.sv
source/mpmc_arbiter.sv
source/mpmc_app_seq.sv
source/mpmc.sv
tb/mig_app_model.sv
tb/mpmc_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
TOP := mpmc_tb
FILELIST := mpmc.f
OBJ_DIR := obj_dir
LOG := sim.log

BIN := $(OBJ_DIR)/$(TOP)
SRCS := $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
